// File: verilog.f
mul_pkg.sv
mul_operand_split.sv
mul_partial_lane.sv
mul_accumulate.sv
mul_top.sv
mul_props.sv
tb_clock.sv
mul_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f verilog.f --top-module mul_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed"
  exit "$status"
fi

./obj_dir/Vmul_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit "$status"
fi

echo "Simulation passed"
exit 0

// File: mul_tb.sv
// ################################################
// Directed tests for mul_top. Responses are sampled
// on the falling edge; inputs change 2 ns after the
// rising edge. Latency is expected to be 3 cycles.
// ################################################

module mul_tb import mul_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESP_TIMEOUT = 10;
  localparam logic [31:0] LFSR_SEED = 32'h3c57_0cab;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  mul_req_t    req_in;
  logic        resp_valid;
  mul_resp_t   resp;
  logic [31:0] lfsr;
  logic [2:0]  strobe_hist;
  mul_resp_t   expect_q [$];

  tb_clock u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  mul_top dut0 (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req_in),
    .resp_valid_o (resp_valid),
    .resp_o       (resp)
  );

  task automatic stop_run(input string why);
    $display("FAIL: see errors above");
    $fatal(1, "%s", why);
  endtask

  task automatic compare_resp(input string name, input mul_resp_t got, input mul_resp_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got.result, exp.result);
      stop_run("response value mismatch");
    end
  endtask

  task automatic check_valid_timing(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      stop_run("response valid timing mismatch");
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Pick a word of the full 64-bit product of the extended operands
  function automatic mul_resp_t expected_resp(input mul_req_t req);
    logic [2*XLEN-1:0] wide_a;
    logic [2*XLEN-1:0] wide_b;
    logic [2*XLEN-1:0] prod;
    mul_resp_t         r;
    wide_a = req.sign_a ? {{XLEN{req.a[XLEN-1]}}, req.a} : {{XLEN{1'b0}}, req.a};
    wide_b = req.sign_b ? {{XLEN{req.b[XLEN-1]}}, req.b} : {{XLEN{1'b0}}, req.b};
    prod = wide_a * wide_b;
    r.result = (req.op == MUL_HIGH) ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
    return r;
  endfunction

  // Last three strobes seen by the DUT
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strobe_hist <= '0;
    end else begin
      strobe_hist <= {strobe_hist[1:0], req_valid};
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      check_valid_timing("resp_valid_o", resp_valid, strobe_hist[2]);
    end
  end

  task automatic wait_reset();
    bit released;
    released = 1'b0;
    for (int i = 0; i < 20 && !released; i++) begin
      @(posedge clk);
      released = rst_n;
    end
    if (!released) begin
      $display("Reset was never released");
      stop_run("reset timeout");
    end
  endtask

  task automatic wait_resp();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < RESP_TIMEOUT && !seen; i++) begin
      @(negedge clk);
      seen = resp_valid;
    end
    if (!seen) begin
      $display("No response within %0d cycles", RESP_TIMEOUT);
      stop_run("response timeout");
    end
  endtask

  task automatic send_req(input mul_req_t req);
    @(posedge clk);
    #2;
    req_valid = 1'b1;
    req_in = req;
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  task automatic check_one(input mul_op_e op, input logic sa, input logic sb,
                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    mul_req_t req;
    req = '{op: op, sign_a: sa, sign_b: sb, a: a, b: b};
    send_req(req);
    wait_resp();
    compare_resp("resp_o", resp, expected_resp(req));
  endtask

  task automatic test_idle();
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_valid_timing("resp_valid_o", resp_valid, 1'b0);
      compare_resp("resp_o", resp, '0);
    end
  endtask

  task automatic test_low_word();
    logic [XLEN-1:0] vals [5];
    vals = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h0001_0000};
    for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          check_one(MUL_LOW, s[1], s[0], vals[i], vals[j]);
        end
      end
      check_one(MUL_LOW, s[1], s[0], 32'h1234_5678, 32'h9abc_def0);
    end
  endtask

  task automatic test_high_signed();
    check_one(MUL_HIGH, 1'b1, 1'b1, 32'h8000_0000, 32'h8000_0000);
    check_one(MUL_HIGH, 1'b1, 1'b1, 32'hffff_ffff, 32'hffff_ffff);
    check_one(MUL_HIGH, 1'b1, 1'b1, 32'hffff_ffff, 32'h0000_0001);
  endtask

  // MULHSU then MULHU
  task automatic test_high_mixed();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    check_one(MUL_HIGH, 1'b1, 1'b0, 32'hffff_ffff, 32'hffff_ffff);
    check_one(MUL_HIGH, 1'b0, 1'b0, 32'hffff_ffff, 32'hffff_ffff);
    for (int i = 0; i < 8; i++) begin
      a = take_bits(XLEN);
      b = take_bits(XLEN);
      check_one(MUL_HIGH, 1'b1, 1'b0, a, b);
      check_one(MUL_HIGH, 1'b0, 1'b0, a, b);
    end
  endtask

  task automatic test_back_to_back();
    mul_req_t    req;
    logic [31:0] bits;
    expect_q.delete();
    fork
      begin
        for (int i = 0; i < 64; i++) begin
          @(posedge clk);
          #2;
          bits = take_bits(3);
          req.op = mul_op_e'(bits[0]);
          req.sign_a = bits[1];
          req.sign_b = bits[2];
          req.a = take_bits(XLEN);
          req.b = take_bits(XLEN);
          req_valid = 1'b1;
          req_in = req;
          expect_q.push_back(expected_resp(req));
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
      end
      begin
        for (int n = 0; n < 64; n++) begin
          wait_resp();
          compare_resp("resp_o", resp, expect_q.pop_front());
        end
      end
    join
  endtask

  initial begin
    req_valid = 1'b0;
    req_in = '0;
    lfsr = LFSR_SEED;
    wait_reset();
    test_idle();
    test_low_word();
    test_high_signed();
    test_high_mixed();
    test_back_to_back();
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: tb_clock.sv
// ################################################
// Free-running 20 ns clock. Reset is held low for
// four rising edges, then released 2 ns after one.
// ################################################

module tb_clock (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

// File: mul_props.sv
// ################################################
// Valid timing checks on mul_top, bound into every
// instance. Assumes a fixed latency of three cycles.
// ################################################

module mul_props (
  input logic clk_i,
  input logic rst_ni,
  input logic req_valid_i,
  input logic resp_valid_o
);
  timeunit 1ns;
  timeprecision 100ps;

  a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(resp_valid_o))
    else $error("resp_valid_o is unknown");

  // No response without a strobe three cycles before
  a_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> $past(req_valid_i, 3))
    else $error("resp_valid_o high without a matching request");

  a_resp_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> ##3 resp_valid_o)
    else $error("request not answered three cycles later");

endmodule

bind mul_top mul_props u_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .req_valid_i  (req_valid_i),
  .resp_valid_o (resp_valid_o)
);

// File: mul_top.sv
// ################################################
// Pipelined 32-bit multiplier, three stages. A new
// request may enter every cycle; the response comes
// three cycles later and must be taken at once.
// ################################################

module mul_top import mul_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_valid_i,
  input  mul_req_t  req_i,
  output logic      resp_valid_o,
  output mul_resp_t resp_o
);

  pp_operand_t [NUM_LANES-1:0] lanes;
  mul_ctl_t                    ctl;
  logic signed [PP_W-1:0]      products [NUM_LANES];

  // Stage 1
  mul_operand_split u_split (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .lanes_o     (lanes),
    .ctl_o       (ctl)
  );

  // Stage 2, one lane per pair of operand halves
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    mul_partial_lane u_lane (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .operand_i (lanes[i]),
      .product_o (products[i])
    );
  end

  // Stage 3
  mul_accumulate u_accum (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ctl_i        (ctl),
    .products_i   (products),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

endmodule

// File: mul_accumulate.sv
// ################################################
// Stage 3. Shifts and sums the four partial products
// and registers the selected word. No back-pressure;
// the response is valid for a single cycle.
// ################################################

module mul_accumulate import mul_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mul_ctl_t               ctl_i,
  input  logic signed [PP_W-1:0] products_i [NUM_LANES],
  output logic                   resp_valid_o,
  output mul_resp_t              resp_o
);

  // Weight of each lane in the full product
  localparam int unsigned LANE_SHIFT [NUM_LANES] = '{0, HALF_W, HALF_W, 2 * HALF_W};

  mul_ctl_t               ctl_q;
  logic [2*XLEN-1:0]      ext_pp [NUM_LANES];
  logic [2*XLEN-1:0]      sum;
  logic [XLEN-1:0]        word_sel;
  logic                   resp_valid_q;
  mul_resp_t              resp_q;

  // Products arrive one cycle after the ctl from stage 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctl_q.valid <= 1'b0;
      ctl_q.op    <= MUL_LOW;
    end else begin
      ctl_q <= ctl_i;
    end
  end

  // Sign-extend each partial product to the full width
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      ext_pp[i] = {{(2*XLEN-PP_W){products_i[i][PP_W-1]}}, products_i[i]};
    end
  end

  // Sum modulo 2^64 equals the product of the extended operands
  always_comb begin
    sum = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      sum = sum + (ext_pp[i] << LANE_SHIFT[i]);
    end
  end

  always_comb begin
    case (ctl_q.op)
      MUL_LOW:  word_sel = sum[XLEN-1:0];
      MUL_HIGH: word_sel = sum[2*XLEN-1:XLEN];
      default:  word_sel = sum[XLEN-1:0];
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= ctl_q.valid;
    end
  end

  // Result holds its last value between responses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_q <= '0;
    end else if (ctl_q.valid) begin
      resp_q.result <= word_sel;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

// File: mul_partial_lane.sv
// ################################################
// Stage 2. One 17x17 signed multiply with a product
// register. The register loads every cycle.
// ################################################

module mul_partial_lane import mul_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  pp_operand_t            operand_i,
  output logic signed [PP_W-1:0] product_o
);

  logic signed [HALF_W:0]   op_a;
  logic signed [HALF_W:0]   op_b;
  logic signed [PP_W-1:0]   product_d;
  logic signed [PP_W-1:0]   product_q;

  // Extension bit on top turns each half into a signed value
  assign op_a = $signed({operand_i.a_ext, operand_i.a_half});
  assign op_b = $signed({operand_i.b_ext, operand_i.b_half});

  // 17 + 17 bits, so the product never overflows PP_W
  assign product_d = op_a * op_b;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      product_q <= '0;
    end else begin
      product_q <= product_d;
    end
  end

  assign product_o = product_q;

endmodule

// File: mul_operand_split.sv
// ################################################
// Stage 1. Splits both operands in halves and builds
// the four lane operand pairs. Lane data registers
// load every cycle; only ctl_o.valid marks real data.
// ################################################

module mul_operand_split import mul_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_valid_i,
  input  mul_req_t                    req_i,
  output pp_operand_t [NUM_LANES-1:0] lanes_o,
  output mul_ctl_t                    ctl_o
);

  logic [HALF_W-1:0]           a_lo;
  logic [HALF_W-1:0]           a_hi;
  logic [HALF_W-1:0]           b_lo;
  logic [HALF_W-1:0]           b_hi;
  logic                        a_hi_ext;
  logic                        b_hi_ext;
  pp_operand_t [NUM_LANES-1:0] lanes_d;
  pp_operand_t [NUM_LANES-1:0] lanes_q;
  mul_ctl_t                    ctl_q;

  assign a_lo = req_i.a[HALF_W-1:0];
  assign a_hi = req_i.a[XLEN-1:HALF_W];
  assign b_lo = req_i.b[HALF_W-1:0];
  assign b_hi = req_i.b[XLEN-1:HALF_W];

  // Only a high half can carry the sign of its operand
  assign a_hi_ext = req_i.sign_a & req_i.a[XLEN-1];
  assign b_hi_ext = req_i.sign_b & req_i.b[XLEN-1];

  always_comb begin
    // al x bl
    lanes_d[0] = '{a_half: a_lo, a_ext: 1'b0, b_half: b_lo, b_ext: 1'b0};
    // al x bh
    lanes_d[1] = '{a_half: a_lo, a_ext: 1'b0, b_half: b_hi, b_ext: b_hi_ext};
    // ah x bl
    lanes_d[2] = '{a_half: a_hi, a_ext: a_hi_ext, b_half: b_lo, b_ext: 1'b0};
    // ah x bh
    lanes_d[3] = '{a_half: a_hi, a_ext: a_hi_ext, b_half: b_hi, b_ext: b_hi_ext};
  end

  // Operand pairs are payload and load unconditionally
  always_ff @(posedge clk_i) begin
    lanes_q <= lanes_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctl_q.valid <= 1'b0;
      ctl_q.op    <= MUL_LOW;
    end else begin
      ctl_q.valid <= req_valid_i;
      ctl_q.op    <= req_i.op;
    end
  end

  assign lanes_o = lanes_q;
  assign ctl_o   = ctl_q;

endmodule

// File: mul_pkg.sv
// ################################################
// Shared widths, opcode and pipeline structs for the
// three-stage 32-bit multiplier. XLEN is fixed at 32
// and split in two 16-bit halves.
// ################################################

package mul_pkg;

  // Operand and result width
  localparam int unsigned XLEN = 32;

  // Each operand is split in two halves of this width
  localparam int unsigned HALF_W = 16;

  // One lane per pair of halves
  localparam int unsigned NUM_LANES = 4;

  // Product of two 17-bit signed values
  localparam int unsigned PP_W = 2 * (HALF_W + 1);

  // Selects which word of the 64-bit product is returned
  typedef enum logic {
    MUL_LOW  = 1'b0,
    MUL_HIGH = 1'b1
  } mul_op_e;

  // Request as seen at the top-level port
  typedef struct packed {
    mul_op_e           op;
    logic              sign_a;
    logic              sign_b;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
  } mul_req_t;

  // Operand pair for one partial-product lane
  // The ext bits make each half a 17-bit signed value
  typedef struct packed {
    logic [HALF_W-1:0] a_half;
    logic              a_ext;
    logic [HALF_W-1:0] b_half;
    logic              b_ext;
  } pp_operand_t;

  // Sideband that travels alongside the data
  typedef struct packed {
    logic    valid;
    mul_op_e op;
  } mul_ctl_t;

  // Response as seen at the top-level port
  typedef struct packed {
    logic [XLEN-1:0] result;
  } mul_resp_t;

endpackage
